/* compile.f */
sys_pkg.sv
matrix_ram.sv
ram_arbiter.sv
wb_host_port.sv
gauss_phase.sv
systemizer.sv
systemizer_top.sv
tb_systemizer.sv

/* gauss_phase.sv */
`timescale 1ns/10ps

module gauss_phase (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  sys_pkg::row_idx_t col,
  output logic              done,
  output logic              fail,
  output sys_pkg::mem_req_t mem_req,
  input  sys_pkg::mem_rsp_t mem_rsp
);
  import sys_pkg::*;

  phase_state_t state;
  phase_state_t elim_nxt;  // Where the elimination loop goes after this row.
  row_idx_t     idx;       // Row under scan or elimination.
  row_idx_t     col_q;     // Pivot column of this phase.
  row_idx_t     pivot_idx; // Row where the pivot was found.
  row_t         pivot_row; // The pivot row itself.
  row_t         cur_row;   // Last row read back from the RAM.
  logic         fail_q;    // No pivot exists in this column.
  logic         last_idx;  // idx points at the bottom row.
  logic         hit;       // The row on rdata has a 1 in the pivot column.

  assign last_idx = idx == row_idx_t'(ROWS - 1);
  assign elim_nxt = last_idx ? DONE : ELIM_RD;
  assign hit      = mem_rsp.rdata[col_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      idx    <= '0;
      col_q  <= '0;
      fail_q <= 1'b0;
    end else begin
      unique case (state)
        IDLE: begin
          if (start) begin
            col_q  <= col;
            idx    <= col;    // Rows above the column already hold earlier pivots.
            fail_q <= 1'b0;
            state  <= SCAN_RD;
          end
        end
        SCAN_RD: if (mem_rsp.gnt) state <= SCAN_CHK;
        SCAN_CHK: begin
          if (mem_rsp.rvalid) begin
            if (hit) begin
              idx   <= '0;                                // Elimination walks all rows.
              state <= (idx == col_q) ? ELIM_RD : SWAP_RD; // No swap when in place.
            end else if (last_idx) begin
              fail_q <= 1'b1;                             // Column has no pivot.
              state  <= DONE;
            end else begin
              idx   <= idx + 1'b1;
              state <= SCAN_RD;
            end
          end
        end
        SWAP_RD:   if (mem_rsp.gnt) state <= SWAP_WR_A;
        SWAP_WR_A: if (mem_rsp.gnt) state <= SWAP_WR_B;
        SWAP_WR_B: if (mem_rsp.gnt) state <= ELIM_RD;
        ELIM_RD: begin
          if (idx == col_q) begin
            idx   <= idx + 1'b1; // The pivot row itself stays as it is.
            state <= elim_nxt;
          end else if (mem_rsp.gnt) begin
            state <= ELIM_CHK;
          end
        end
        ELIM_CHK: begin
          if (mem_rsp.rvalid) begin
            if (hit) begin
              state <= ELIM_WR;
            end else begin
              idx   <= idx + 1'b1; // Row is already clear in this column.
              state <= elim_nxt;
            end
          end
        end
        ELIM_WR: begin
          if (mem_rsp.gnt) begin
            idx   <= idx + 1'b1;
            state <= elim_nxt;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Row data registers.
  always_ff @(posedge clk) begin
    if (mem_rsp.rvalid) begin
      cur_row <= mem_rsp.rdata; // Every read result is kept for the next write.
    end
    if (state == SCAN_CHK && mem_rsp.rvalid && hit) begin
      pivot_row <= mem_rsp.rdata;
      pivot_idx <= idx;
    end
  end

  always_comb begin
    mem_req = '0;
    unique case (state)
      SCAN_RD: begin
        mem_req.req  = 1'b1;
        mem_req.addr = idx;
      end
      SWAP_RD: begin
        mem_req.req  = 1'b1;
        mem_req.addr = col_q; // Fetch the row that the pivot displaces.
      end
      SWAP_WR_A: begin
        mem_req.req   = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = col_q;
        mem_req.wdata = pivot_row;
      end
      SWAP_WR_B: begin
        mem_req.req   = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = pivot_idx;
        mem_req.wdata = cur_row; // The displaced row takes the pivot's old place.
      end
      ELIM_RD: begin
        mem_req.req  = idx != col_q;
        mem_req.addr = idx;
      end
      ELIM_WR: begin
        mem_req.req   = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = idx;
        mem_req.wdata = cur_row ^ pivot_row; // Addition over GF(2).
      end
      default: mem_req = '0;
    endcase
  end

  assign done = state == DONE;
  assign fail = (state == DONE) && fail_q;

  // The sequencer must wait for done before it starts the next column.
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (state == IDLE));

endmodule

/* matrix_ram.sv */
`timescale 1ns/10ps

module matrix_ram (
  input  logic              clk,
  input  logic              we,
  input  sys_pkg::row_idx_t addr,
  input  sys_pkg::row_t     wdata,
  output sys_pkg::row_t     rdata
);
  import sys_pkg::*;

  row_t mem [ROWS]; // One word per matrix row.

  // The array is read every cycle, so rdata follows the address of the cycle before.
  // A write returns the old contents of the row, the array is read before it is written.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata; // Store the new row.
    end
    rdata <= mem[addr];   // Registered read, one cycle of latency.
  end

endmodule

/* ram_arbiter.sv */
`timescale 1ns/10ps

module ram_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  input  sys_pkg::mem_req_t host_req,
  output sys_pkg::mem_rsp_t host_rsp,
  input  sys_pkg::mem_req_t eng_req,
  output sys_pkg::mem_rsp_t eng_rsp,
  output logic              ram_we,
  output sys_pkg::row_idx_t ram_addr,
  output sys_pkg::row_t     ram_wdata,
  input  sys_pkg::row_t     ram_rdata
);
  import sys_pkg::*;

  logic     host_gnt;  // Host owns the RAM this cycle.
  logic     eng_gnt;   // Engine owns the RAM this cycle.
  logic     host_rd_q; // Data on ram_rdata belongs to a host read.
  logic     eng_rd_q;  // Data on ram_rdata belongs to an engine read.
  mem_req_t win;       // Request that reaches the RAM.

  assign host_gnt = host_req.req;                  // Host always wins.
  assign eng_gnt  = eng_req.req && !host_req.req;  // Engine only gets idle cycles.
  assign win      = host_req.req ? host_req : eng_req;

  assign ram_we    = win.req && win.we; // No request means no write.
  assign ram_addr  = win.addr;
  assign ram_wdata = win.wdata;

  // Remember who issued the read so the data goes back to that side only.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_rd_q <= 1'b0;
      eng_rd_q  <= 1'b0;
    end else begin
      host_rd_q <= host_gnt && !host_req.we; // Granted host read.
      eng_rd_q  <= eng_gnt && !eng_req.we;   // Granted engine read.
    end
  end

  assign host_rsp = '{gnt: host_gnt, rvalid: host_rd_q, rdata: ram_rdata};
  assign eng_rsp  = '{gnt: eng_gnt, rvalid: eng_rd_q, rdata: ram_rdata};

  // A stalled engine request stays up with the same fields until it is granted.
  a_eng_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (eng_req.req && !eng_gnt) |=> (eng_req.req && $stable(eng_req)));

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_systemizer -f compile.f -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || echo "Build or simulation did not complete."
grep -q "^SIMULATION PASSED$" sim.log 2>/dev/null && echo "Result: pass" && exit 0 \
  || { echo "Result: fail"; exit 1; }

/* sys_pkg.sv */
package sys_pkg;

  localparam int ROWS = 8;   // Rows of the matrix, one RAM word each.
  localparam int COLS = 16;  // Columns of the matrix, the left 8 form the pivot block.

  typedef logic [COLS-1:0] row_t;     // One full matrix row.
  typedef logic [2:0]      row_idx_t; // Row index, also used as a pivot column index.
  typedef logic [4:0]      wb_adr_t;  // Wishbone word address.

  localparam wb_adr_t CTRL_ADR = 5'd16; // Control register, bit 0 written as 1 starts a run.
  localparam wb_adr_t STAT_ADR = 5'd17; // Status register, read only.

  // Request from one requester toward the RAM arbiter.
  typedef struct packed {
    logic     req;   // Held high with stable fields until gnt is seen.
    logic     we;    // High for a write, low for a read.
    row_idx_t addr;  // Row being accessed.
    row_t     wdata; // Write data, ignored on reads.
  } mem_req_t;

  // Response from the arbiter to one requester.
  typedef struct packed {
    logic gnt;    // Same-cycle grant of the current request.
    logic rvalid; // Read data valid, one cycle after the read grant.
    row_t rdata;  // Read data.
  } mem_rsp_t;

  // Run status as seen by the host.
  typedef struct packed {
    logic busy;    // A run is in progress.
    logic done;    // The last run has ended.
    logic fail;    // The last run found a column without a pivot.
    logic success; // The last run produced the identity on the left.
  } sys_status_t;

  typedef enum logic [3:0] {
    IDLE,
    SCAN_RD,
    SCAN_CHK,
    SWAP_RD,
    SWAP_WR_A,
    SWAP_WR_B,
    ELIM_RD,
    ELIM_CHK,
    ELIM_WR,
    DONE
  } phase_state_t;

endpackage

/* systemizer.sv */
`timescale 1ns/10ps

module systemizer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output sys_pkg::sys_status_t status,
  output sys_pkg::mem_req_t    mem_req,
  input  sys_pkg::mem_rsp_t    mem_rsp
);
  import sys_pkg::*;

  logic     running;     // A run is in progress.
  logic     done_q;      // The last run has ended.
  logic     fail_q;      // Sticky, set by the first failing phase.
  logic     phase_start; // One-cycle kick for the phase engine.
  logic     phase_done;  // The phase engine has finished a column.
  logic     phase_fail;  // The finished column had no pivot.
  logic     last_col;    // The current phase handles the last pivot column.
  row_idx_t phase_col;   // Pivot column of the current phase.

  assign last_col = phase_col == row_idx_t'(ROWS - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running     <= 1'b0;
      done_q      <= 1'b0;
      fail_q      <= 1'b0;
      phase_start <= 1'b0;
      phase_col   <= '0;
    end else begin
      phase_start <= 1'b0;
      if (start && !running) begin
        running     <= 1'b1;  // A start during a run is dropped.
        done_q      <= 1'b0;
        fail_q      <= 1'b0;
        phase_col   <= '0;
        phase_start <= 1'b1;
      end else if (running && phase_done) begin
        fail_q <= fail_q | phase_fail;
        if (phase_fail || last_col) begin
          running <= 1'b0;    // Stop at the first missing pivot or the last column.
          done_q  <= 1'b1;
        end else begin
          phase_col   <= phase_col + 1'b1;
          phase_start <= 1'b1;
        end
      end
    end
  end

  assign status.busy    = running;
  assign status.done    = done_q;
  assign status.fail    = fail_q;
  assign status.success = done_q && !fail_q; // Exactly one of the two once done is set.

  gauss_phase u_phase (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (phase_start),
    .col     (phase_col),
    .done    (phase_done),
    .fail    (phase_fail),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  // A phase only ever ends inside a run that started it.
  a_done_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    phase_done |-> running);

endmodule

/* systemizer_top.sv */
`timescale 1ns/10ps

module systemizer_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  sys_pkg::wb_adr_t adr,
  input  sys_pkg::row_t    dat_w,
  output sys_pkg::row_t    dat_r,
  output logic             ack
);
  import sys_pkg::*;

  mem_req_t    host_req;  // Host port toward the arbiter.
  mem_rsp_t    host_rsp;
  mem_req_t    eng_req;   // Elimination engine toward the arbiter.
  mem_rsp_t    eng_rsp;
  logic        start;     // Start pulse from the control register.
  sys_status_t status;    // Run status for the status register.
  logic        ram_we;
  row_idx_t    ram_addr;
  row_t        ram_wdata;
  row_t        ram_rdata;

  wb_host_port u_host (
    .clk      (clk),
    .rst_n    (rst_n),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .start    (start),
    .status   (status)
  );

  systemizer u_sys (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .status  (status),
    .mem_req (eng_req),
    .mem_rsp (eng_rsp)
  );

  ram_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .eng_req   (eng_req),
    .eng_rsp   (eng_rsp),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  matrix_ram u_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

/* tb_systemizer.sv */
`timescale 1ns/10ps

module tb_systemizer;
  import sys_pkg::*;

  localparam int NTESTS     = 8;   // Entries in the stimulus table.
  localparam int WB_TIMEOUT = 20;  // Cycles allowed for one ack.
  localparam int POLL_LIMIT = 400; // Status reads allowed for one run.

  logic    clk;
  logic    rst_n;
  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  row_t    dat_w;
  row_t    dat_r;
  logic    ack;

  string       test_name [NTESTS];        // Name printed in error lines.
  logic        test_random [NTESTS];      // Rows come from the xorshift generator.
  row_t        test_rows [NTESTS][ROWS];  // Matrix loaded for each entry.
  row_t        mdl [ROWS];                // Working matrix of the reference model.
  logic        mdl_fail;                  // The model found a column without a pivot.
  logic [31:0] rng;                       // Xorshift state.
  int          val_errs;                  // Wrong values seen.
  int          tmo_errs;                  // Waits that ran out.

  systemizer_top u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #10 clk = ~clk; // 20 ns period.

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Gauss-Jordan over GF(2) on mdl, lowest pivot first, stops at the first empty column.
  task automatic run_model();
    int   piv;
    row_t tmp;
    mdl_fail = 1'b0;
    for (int c = 0; c < ROWS; c++) begin
      if (!mdl_fail) begin
        piv = -1;
        for (int r = ROWS - 1; r >= c; r--) begin
          if (mdl[r][c]) piv = r; // Walking down leaves the lowest index.
        end
        if (piv < 0) begin
          mdl_fail = 1'b1;        // The matrix stays as it is at this point.
        end else begin
          tmp      = mdl[c];
          mdl[c]   = mdl[piv];    // Swap is a no-op when piv equals c.
          mdl[piv] = tmp;
          for (int r = 0; r < ROWS; r++) begin
            if (r != c && mdl[r][c]) mdl[r] = mdl[r] ^ mdl[c];
          end
        end
      end
    end
  endtask

  task automatic check_row(input string name, input row_t exp, input row_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_status(input string name, input sys_status_t exp,
                              input sys_status_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act); // busy done fail success.
      val_errs++;
    end
  endtask

  // One bus access. Lat counts the cycles from stb being sampled to ack.
  task automatic wb_access(input logic wr, input wb_adr_t a, input row_t wd,
                           output row_t rd, output int lat);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    rd  = '0;
    lat = -1;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= wd;
    while (!got && n < WB_TIMEOUT) begin
      @(negedge clk); // Ack and dat_r are registered, so they are settled here.
      n++;
      got = ack;
      if (got) rd = dat_r;
    end
    if (got) begin
      lat = n - 1;
    end else begin
      $display("No ack arrived for the access to address %0d.", a);
      tmo_errs++;
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t a, input row_t d, output int lat);
    row_t unused;
    wb_access(1'b1, a, d, unused, lat);
  endtask

  task automatic wb_read(input wb_adr_t a, output row_t d, output int lat);
    wb_access(1'b0, a, '0, d, lat);
  endtask

  task automatic read_status(output sys_status_t s, output int lat);
    row_t d;
    wb_read(STAT_ADR, d, lat);
    s = sys_status_t'(d[3:0]); // Status sits in the low bits.
  endtask

  task automatic build_table();
    int tries;
    test_name[0] = "identity_prefix";
    test_rows[0] = '{16'h5A01, 16'hC302, 16'h7E04, 16'h1908,
                     16'hE410, 16'h8B20, 16'h2F40, 16'hD680};
    test_name[1] = "upper_tri";
    test_rows[1] = '{16'h12FF, 16'h34FE, 16'h56FC, 16'h78F8,
                     16'h9AF0, 16'hBCE0, 16'hDEC0, 16'hF080};
    test_name[2] = "row_reverse"; // The first four columns need a swap.
    test_rows[2] = '{16'h1180, 16'h2240, 16'h3320, 16'h4410,
                     16'h5508, 16'h6604, 16'h7702, 16'h8801};
    test_name[3] = "zero_col0";
    test_rows[3] = '{16'h0102, 16'h0204, 16'h0308, 16'h0410,
                     16'h0520, 16'h0640, 16'h0780, 16'h0806};
    test_name[4] = "equal_rows";  // Rows 2 and 5 match.
    test_rows[4] = '{16'h0001, 16'h0002, 16'h0A0C, 16'h0008,
                     16'h0010, 16'h0A0C, 16'h0040, 16'h0080};
    test_name[5] = "restart_fixed";
    test_rows[5] = '{16'hA180, 16'h3B06, 16'h4C03, 16'h9518,
                     16'h660C, 16'h0F60, 16'hD230, 16'h77C0};
    test_name[6] = "random_a";
    test_name[7] = "random_b";
    for (int t = 0; t < NTESTS; t++) test_random[t] = (t >= 6);
    for (int t = 0; t < NTESTS; t++) begin
      if (test_random[t]) begin
        tries    = 0;
        mdl_fail = 1'b1;
        while (mdl_fail && tries < 64) begin // Redraw until the matrix is invertible.
          for (int r = 0; r < ROWS; r++) begin
            rng             = xorshift32(rng);
            test_rows[t][r] = rng[15:0];
            mdl[r]          = rng[15:0];
          end
          run_model();
          tries++;
        end
      end
    end
  endtask

  task automatic run_test(input int t);
    row_t        d;
    sys_status_t s;
    sys_status_t exp_s;
    int          lat;
    int          polls;
    for (int r = 0; r < ROWS; r++) wb_write(wb_adr_t'(r), test_rows[t][r], lat);
    for (int r = 0; r < ROWS; r++) begin
      wb_read(wb_adr_t'(r), d, lat);
      check_row($sformatf("%s load row %0d", test_name[t], r), test_rows[t][r], d);
    end
    for (int r = 0; r < ROWS; r++) mdl[r] = test_rows[t][r];
    run_model();
    wb_write(CTRL_ADR, 16'h0001, lat);
    read_status(s, lat);               // The engine is still in its first column here.
    exp_s      = '0;
    exp_s.busy = 1'b1;
    check_status($sformatf("%s busy", test_name[t]), exp_s, s);
    if (lat != 1) begin
      $display("FAIL %s status latency: expected 1, actual %0d", test_name[t], lat);
      val_errs++;
    end
    wb_read(wb_adr_t'(0), d, lat);      // The host must win the RAM at once.
    if (lat != 2) begin
      $display("FAIL %s row read latency: expected 2, actual %0d", test_name[t], lat);
      val_errs++;
    end
    polls = 0;
    s     = '0;
    while (!s.done && polls < POLL_LIMIT) begin
      read_status(s, lat);
      polls++;
    end
    if (!s.done) begin
      $display("The run of %s did not finish within %0d status reads.", test_name[t], polls);
      tmo_errs++;
    end
    exp_s         = '0;
    exp_s.done    = 1'b1;
    exp_s.fail    = mdl_fail;
    exp_s.success = !mdl_fail;
    check_status($sformatf("%s final", test_name[t]), exp_s, s);
    for (int r = 0; r < ROWS; r++) begin
      wb_read(wb_adr_t'(r), d, lat);
      check_row($sformatf("%s result row %0d", test_name[t], r), mdl[r], d);
      if (!mdl_fail) begin
        check_row($sformatf("%s identity row %0d", test_name[t], r),
                  row_t'(1 << r), {8'h00, d[7:0]});
      end
    end
  endtask

  initial begin
    sys_status_t s;
    int          lat;
    clk      = 1'b0;
    rst_n    = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    val_errs = 0;
    tmo_errs = 0;
    rng      = 32'd30084;
    build_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    read_status(s, lat);
    check_status("reset_status", '0, s);
    for (int t = 0; t < NTESTS; t++) run_test(t);
    $display("Errors: %0d wrong values, %0d timeouts", val_errs, tmo_errs);
    if (val_errs == 0 && tmo_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* wb_host_port.sv */
`timescale 1ns/10ps

module wb_host_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  sys_pkg::wb_adr_t     adr,
  input  sys_pkg::row_t        dat_w,
  output sys_pkg::row_t        dat_r,
  output logic                 ack,
  output sys_pkg::mem_req_t    host_req,
  input  sys_pkg::mem_rsp_t    host_rsp,
  output logic                 start,
  input  sys_pkg::sys_status_t status
);
  import sys_pkg::*;

  logic acc;     // A bus cycle is waiting for its ack.
  logic is_row;  // The address hits a matrix row.
  logic is_ctrl; // The address hits the control register.
  logic is_stat; // The address hits the status register.
  logic rd_pend; // A row read was granted and its data is still on the way.

  assign acc     = cyc && stb && !ack;    // Ack is a pulse, so a high ack closes the access.
  assign is_row  = adr < wb_adr_t'(ROWS);
  assign is_ctrl = adr == CTRL_ADR;
  assign is_stat = adr == STAT_ADR;

  always_comb begin
    host_req.req   = acc && is_row && !rd_pend; // Only one RAM request per bus cycle.
    host_req.we    = we;
    host_req.addr  = adr[2:0];                   // Row number within the matrix.
    host_req.wdata = dat_w;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      start   <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      ack   <= 1'b0; // Default, ack lasts one cycle.
      start <= 1'b0; // Default, start lasts one cycle.
      if (host_rsp.rvalid) begin
        ack     <= 1'b1; // Read data has arrived.
        rd_pend <= 1'b0;
      end else if (acc && is_row) begin
        if (host_rsp.gnt) begin
          ack     <= we;  // A write is done once it is granted.
          rd_pend <= !we; // A read still waits for rvalid.
        end
      end else if (acc) begin
        ack   <= 1'b1;                     // Registers answer in one cycle.
        start <= is_ctrl && we && dat_w[0];
      end
    end
  end

  // Read data path, status sits in the low bits and unmapped reads return zero.
  always_ff @(posedge clk) begin
    if (host_rsp.rvalid) begin
      dat_r <= host_rsp.rdata;
    end else if (acc && !is_row) begin
      dat_r <= is_stat ? {{(COLS - $bits(sys_status_t)){1'b0}}, status} : '0;
    end
  end

  // The master holds stb until it samples ack, so ack is only ever seen inside a cycle.
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (cyc && stb));

endmodule
